/* aluTop.f */
rtl/aluPkg.sv
rtl/aluOperandRegs.sv
rtl/aluCompute.sv
rtl/aluResultRegs.sv
rtl/aluTop.sv
testbench/aluTb.sv

/* rtl/aluCompute.sv */
// ALU compute stage
// Arithmetic and logic on the latched operands, registered result and flags
`timescale 1ns/100ps

module aluCompute import aluPkg::*; (
  input  logic     DSPCLK,
  input  logic     rst,
  input  dataWordT xOp,
  input  dataWordT yOp,
  input  aluOpT    opS1,
  input  logic     satS1,
  input  logic     toAfS1,
  input  logic     validS1,
  output dataWordT resS2,
  output astatT    flagsS2,
  output logic     satS2,
  output logic     toAfS2,
  output logic     validS2
);

  logic [16:0] sum;
  dataWordT yAdd;
  dataWordT res;
  logic carry, ovf;
  logic isArith;

  // Subtract is X + ~Y + 1
  assign yAdd = (opS1 == opSub) ? ~yOp : yOp;
  assign sum = {1'b0, xOp} + {1'b0, yAdd} + {16'b0, opS1 == opSub};
  assign isArith = (opS1 == opAdd) || (opS1 == opSub);

  always_comb begin
    case (opS1)
      opAdd,
      opSub:   res = sum[15:0];
      opAnd:   res = xOp & yOp;
      opOr:    res = xOp | yOp;
      opXor:   res = xOp ^ yOp;
      opPassX: res = xOp;
      opPassY: res = yOp;
      default: res = ~xOp;
    endcase
  end

  // Same-sign operands with a differing result sign
  assign ovf = isArith && (xOp[15] == yAdd[15]) && (sum[15] != xOp[15]);
  assign carry = isArith && sum[16];

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      validS2 <= 1'b0;
    end else begin
      validS2 <= validS1;
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (validS1) begin
      resS2          <= res;
      flagsS2[flagZ] <= (res == '0);
      flagsS2[flagN] <= res[15];
      flagsS2[flagC] <= carry;
      flagsS2[flagV] <= ovf;
      satS2          <= satS1;
      toAfS2         <= toAfS1;
    end
  end

endmodule

/* rtl/aluOperandRegs.sv */
// ALU operand registers
// Banked AX0/AX1/AY0/AY1, X and Y operand forming, stage 1 pipeline register
`timescale 1ns/100ps

module aluOperandRegs import aluPkg::*; (
  input  logic     DSPCLK,
  input  logic     rst,
  input  dataWordT dmdIn,
  input  dataWordT pmdIn,
  input  logic     accPm,
  input  logic     shadow,
  input  logic     loadAx0,
  input  logic     loadAx1,
  input  logic     loadAy0,
  input  logic     loadAy1,
  input  logic     execute,
  input  aluOpT    aluOp,
  input  xSrcT     xSrc,
  input  ySrcT     ySrc,
  input  logic     zeroX,
  input  logic     zeroY,
  input  logic     invX,
  input  logic     invY,
  input  dataWordT constVal,
  input  logic     satEn,
  input  logic     toAf,
  input  dataWordT arWord,
  input  dataWordT afWord,
  input  readSrcT  readSrc,
  output dataWordT xOp,
  output dataWordT yOp,
  output aluOpT    opS1,
  output logic     satS1,
  output logic     toAfS1,
  output logic     validS1,
  output dataWordT operandReadWord
);

  // Register slots within a bank
  localparam int slotAx0 = 0;
  localparam int slotAx1 = 1;
  localparam int slotAy0 = 2;
  localparam int slotAy1 = 3;

  // Bank 0 is primary, bank 1 is shadow
  dataWordT opBank [2][4];
  dataWordT loadBus;
  logic [3:0] loadVec;
  dataWordT ax0, ax1, ay0, ay1;
  dataWordT xSel, ySel, xZero, yZero;

  assign loadBus = accPm ? pmdIn : dmdIn;
  assign loadVec = {loadAy1, loadAy0, loadAx1, loadAx0};

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      opBank <= '{default: '0};
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (loadVec[i]) begin
          opBank[shadow][i] <= loadBus;
        end
      end
    end
  end

  // Current bank view
  assign ax0 = opBank[shadow][slotAx0];
  assign ax1 = opBank[shadow][slotAx1];
  assign ay0 = opBank[shadow][slotAy0];
  assign ay1 = opBank[shadow][slotAy1];

  always_comb begin
    case (xSrc)
      xAx0:    xSel = ax0;
      xAx1:    xSel = ax1;
      xAr:     xSel = arWord;
      default: xSel = '0;
    endcase
    case (ySrc)
      yAy0:    ySel = ay0;
      yAy1:    ySel = ay1;
      yAf:     ySel = afWord;
      default: ySel = constVal;
    endcase
  end

  // Zero forcing first, then inversion
  assign xZero = zeroX ? '0 : xSel;
  assign yZero = zeroY ? '0 : ySel;

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      validS1 <= 1'b0;
    end else begin
      validS1 <= execute;
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (execute) begin
      xOp    <= invX ? ~xZero : xZero;
      yOp    <= invY ? ~yZero : yZero;
      opS1   <= aluOp;
      satS1  <= satEn;
      toAfS1 <= toAf;
    end
  end

  // Operand half of the readback mux
  always_comb begin
    case (readSrc)
      rdAx0:   operandReadWord = ax0;
      rdAx1:   operandReadWord = ax1;
      rdAy0:   operandReadWord = ay0;
      rdAy1:   operandReadWord = ay1;
      default: operandReadWord = '0;
    endcase
  end

endmodule

/* rtl/aluPkg.sv */
// ALU package
// Word, operation, selector and status types shared by the ALU pipeline stages

package aluPkg;

  // Data word for operands, results and both buses
  typedef logic [15:0] dataWordT;

  // Status flags: zero, negative, carry, overflow
  typedef logic [3:0] astatT;

  localparam int flagZ = 0;
  localparam int flagN = 1;
  localparam int flagC = 2;
  localparam int flagV = 3;

  typedef enum logic [2:0] {
    opAdd,
    opSub,    // X minus Y
    opAnd,
    opOr,
    opXor,
    opPassX,
    opPassY,
    opNotX
  } aluOpT;

  typedef enum logic [1:0] {
    xAx0,
    xAx1,
    xAr
  } xSrcT;

  typedef enum logic [1:0] {
    yAy0,
    yAy1,
    yAf,
    yConst
  } ySrcT;

  typedef enum logic [2:0] {
    rdAx0,
    rdAx1,
    rdAy0,
    rdAy1,
    rdAr,
    rdAf,
    rdAstat
  } readSrcT;

  // Saturation limits for a 16-bit two's complement AR
  localparam dataWordT satPos = 16'h7fff;
  localparam dataWordT satNeg = 16'h8000;

endpackage

/* rtl/aluResultRegs.sv */
// ALU result registers
// Banked AF and AR with AR saturation, status register and bus readback
`timescale 1ns/100ps

module aluResultRegs import aluPkg::*; (
  input  logic     DSPCLK,
  input  logic     rst,
  input  dataWordT dmdIn,
  input  dataWordT pmdIn,
  input  logic     accPm,
  input  logic     shadow,
  input  logic     moveAr,
  input  dataWordT resS2,
  input  astatT    flagsS2,
  input  logic     satS2,
  input  logic     toAfS2,
  input  logic     validS2,
  input  logic     readEn,
  input  readSrcT  readSrc,
  input  dataWordT operandReadWord,
  output dataWordT arWord,
  output dataWordT afWord,
  output astatT    astat,
  output dataWordT dmdOut
);

  // Index 0 primary, 1 shadow
  dataWordT afBank [2];
  dataWordT arBank [2];
  dataWordT moveBus;
  dataWordT arIn;
  dataWordT readWord;

  assign moveBus = accPm ? pmdIn : dmdIn;

  // Clamp by the carry when overflow hits with saturation on
  always_comb begin
    if (satS2 && flagsS2[flagV]) begin
      arIn = flagsS2[flagC] ? satNeg : satPos;
    end else begin
      arIn = resS2;
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      afBank <= '{default: '0};
      arBank <= '{default: '0};
      astat  <= '0;
    end else begin
      if (validS2) begin
        astat <= flagsS2;
        if (toAfS2) begin
          afBank[shadow] <= resS2;
        end
      end
      // A move to AR overrides the pipeline write
      if (moveAr) begin
        arBank[shadow] <= moveBus;
      end else if (validS2 && !toAfS2) begin
        arBank[shadow] <= arIn;
      end
    end
  end

  assign arWord = arBank[shadow];
  assign afWord = afBank[shadow];

  always_comb begin
    case (readSrc)
      rdAr:    readWord = arWord;
      rdAf:    readWord = afWord;
      rdAstat: readWord = dataWordT'(astat);
      default: readWord = operandReadWord;
    endcase
  end

  assign dmdOut = readEn ? readWord : '0;

endmodule

/* rtl/aluTop.sv */
// ALU top level
// Three-stage pipeline of operand forming, compute and result write
`timescale 1ns/100ps

module aluTop import aluPkg::*; (
  input  logic     DSPCLK,
  input  logic     rst,
  input  dataWordT dmdIn,
  input  dataWordT pmdIn,
  input  logic     accPm,
  input  logic     shadow,
  input  logic     loadAx0,
  input  logic     loadAx1,
  input  logic     loadAy0,
  input  logic     loadAy1,
  input  logic     moveAr,
  input  logic     execute,
  input  aluOpT    aluOp,
  input  xSrcT     xSrc,
  input  ySrcT     ySrc,
  input  logic     zeroX,
  input  logic     zeroY,
  input  logic     invX,
  input  logic     invY,
  input  dataWordT constVal,
  input  logic     satEn,
  input  logic     toAf,
  input  logic     readEn,
  input  readSrcT  readSrc,
  output dataWordT dmdOut,
  output astatT    astat
);

  // Stage 1 outputs
  dataWordT xOp, yOp;
  aluOpT opS1;
  logic satS1, toAfS1, validS1;
  // Stage 2 outputs
  dataWordT resS2;
  astatT flagsS2;
  logic satS2, toAfS2, validS2;
  // Feedback and readback
  dataWordT arWord, afWord, operandReadWord;

  aluOperandRegs operandRegs_i (
    .DSPCLK(DSPCLK), .rst(rst), .dmdIn(dmdIn), .pmdIn(pmdIn),
    .accPm(accPm), .shadow(shadow),
    .loadAx0(loadAx0), .loadAx1(loadAx1), .loadAy0(loadAy0), .loadAy1(loadAy1),
    .execute(execute), .aluOp(aluOp), .xSrc(xSrc), .ySrc(ySrc),
    .zeroX(zeroX), .zeroY(zeroY), .invX(invX), .invY(invY),
    .constVal(constVal), .satEn(satEn), .toAf(toAf),
    .arWord(arWord), .afWord(afWord), .readSrc(readSrc),
    .xOp(xOp), .yOp(yOp), .opS1(opS1), .satS1(satS1), .toAfS1(toAfS1),
    .validS1(validS1), .operandReadWord(operandReadWord)
  );

  aluCompute compute_i (
    .DSPCLK(DSPCLK), .rst(rst), .xOp(xOp), .yOp(yOp), .opS1(opS1),
    .satS1(satS1), .toAfS1(toAfS1), .validS1(validS1),
    .resS2(resS2), .flagsS2(flagsS2), .satS2(satS2), .toAfS2(toAfS2),
    .validS2(validS2)
  );

  aluResultRegs resultRegs_i (
    .DSPCLK(DSPCLK), .rst(rst), .dmdIn(dmdIn), .pmdIn(pmdIn),
    .accPm(accPm), .shadow(shadow), .moveAr(moveAr),
    .resS2(resS2), .flagsS2(flagsS2), .satS2(satS2), .toAfS2(toAfS2),
    .validS2(validS2), .readEn(readEn), .readSrc(readSrc),
    .operandReadWord(operandReadWord),
    .arWord(arWord), .afWord(afWord), .astat(astat), .dmdOut(dmdOut)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the ALU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module aluTb -f aluTop.f -o aluSim

out=$(./obj_dir/aluSim 2>&1 || true)
echo "$out"

if grep -q "Test completed successfully" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* testbench/aluTb.sv */
// ALU testbench
// Banked register model with a reference ALU, checks readback three cycles after issue
`timescale 1ns/100ps

module aluTb import aluPkg::*; ();

  logic DSPCLK = 1'b0;
  logic rst;
  dataWordT dmdIn, pmdIn, constVal, dmdOut;
  logic accPm, shadow, loadAx0, loadAx1, loadAy0, loadAy1, moveAr, execute;
  aluOpT aluOp;
  xSrcT xSrc;
  ySrcT ySrc;
  logic zeroX, zeroY, invX, invY, satEn, toAf, readEn;
  readSrcT readSrc;
  astatT astat;

  // Model state with bank 0 primary and bank 1 shadow
  dataWordT mOp [2][4];
  dataWordT mAr [2];
  dataWordT mAf [2];
  astatT mAstat;
  int bank;
  int cyc = 0;

  // Pending comparisons and the readback source for each cycle
  int expDue [$];
  dataWordT expVal [$];
  astatT expFlags [$];
  readSrcT readAt [int];

  aluTop dut_i (
    .DSPCLK(DSPCLK), .rst(rst), .dmdIn(dmdIn), .pmdIn(pmdIn), .accPm(accPm),
    .shadow(shadow), .loadAx0(loadAx0), .loadAx1(loadAx1), .loadAy0(loadAy0),
    .loadAy1(loadAy1), .moveAr(moveAr), .execute(execute), .aluOp(aluOp),
    .xSrc(xSrc), .ySrc(ySrc), .zeroX(zeroX), .zeroY(zeroY), .invX(invX),
    .invY(invY), .constVal(constVal), .satEn(satEn), .toAf(toAf),
    .readEn(readEn), .readSrc(readSrc), .dmdOut(dmdOut), .astat(astat)
  );

  always #4 DSPCLK = ~DSPCLK;

  always @(posedge DSPCLK) cyc <= cyc + 1;

  // Expected word and flags with the flags packed as {V, C, N, Z}
  function automatic logic [19:0] refAlu(aluOpT op, dataWordT xv, dataWordT yv,
                                         logic zx, logic zy, logic ix, logic iy);
    dataWordT x, y, yc, res;
    logic [16:0] s;
    logic c, v;
    x = zx ? 16'h0 : xv;
    y = zy ? 16'h0 : yv;
    if (ix) x = ~x;
    if (iy) y = ~y;
    c = 1'b0;
    v = 1'b0;
    case (op)
      opAdd: begin
        s = {1'b0, x} + {1'b0, y};
        res = s[15:0];
        c = s[16];
        v = (x[15] == y[15]) && (res[15] != x[15]);
      end
      opSub: begin
        yc = ~y;
        s = {1'b0, x} + {1'b0, yc} + 17'd1;
        res = s[15:0];
        c = s[16];
        v = (x[15] == yc[15]) && (res[15] != x[15]);
      end
      opAnd:   res = x & y;
      opOr:    res = x | y;
      opXor:   res = x ^ y;
      opPassX: res = x;
      opPassY: res = y;
      default: res = ~x;
    endcase
    return {v, c, res[15], res == 16'h0, res};
  endfunction

  function automatic dataWordT refSat(dataWordT res, astatT fl, logic sat);
    if (sat && fl[3]) return fl[2] ? 16'h8000 : 16'h7fff;
    return res;
  endfunction

  function automatic logic coin(int pct);
    return $urandom_range(99, 0) < pct;
  endfunction

  task automatic checkValue(string name, dataWordT got, dataWordT exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  always @(negedge DSPCLK) begin
    if (expDue.size() != 0 && expDue[0] == cyc) begin
      checkValue("dmdOut", dmdOut, expVal[0]);
      checkValue("astat", {12'h0, astat}, {12'h0, expFlags[0]});
      void'(expDue.pop_front());
      void'(expVal.pop_front());
      void'(expFlags.pop_front());
    end else if (!readEn) begin
      // Bus idles at zero when readback is off
      checkValue("dmdOut", dmdOut, 16'h0);
    end
  end

  // Advance one cycle, clear strobes, then set up any scheduled readback
  task automatic step();
    @(posedge DSPCLK);
    #1;
    {loadAx0, loadAx1, loadAy0, loadAy1, moveAr, execute} = '0;
    if (readAt.exists(cyc)) begin
      readEn = 1'b1;
      readSrc = readAt[cyc];
      readAt.delete(cyc);
    end else begin
      readEn = 1'b0;
    end
  endtask

  task automatic expectAt(int due, dataWordT val, astatT fl);
    expDue.push_back(due);
    expVal.push_back(val);
    expFlags.push_back(fl);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (expDue.size() != 0 && n < 20) begin
      step();
      n++;
    end
    if (expDue.size() != 0) begin
      $display("Timeout: pipeline results never reached the readback bus");
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic readCheck(readSrcT src, dataWordT val);
    readEn = 1'b1;
    readSrc = src;
    expectAt(cyc, val, mAstat);
    step();
  endtask

  task automatic setBank(int b);
    bank = b;
    shadow = (b != 0);
  endtask

  task automatic checkBank(int b);
    setBank(b);
    for (int slot = 0; slot < 4; slot++) readCheck(readSrcT'(3'(slot)), mOp[b][slot]);
    readCheck(rdAr, mAr[b]);
    readCheck(rdAf, mAf[b]);
    readCheck(rdAstat, {12'h0, mAstat});
  endtask

  task automatic loadReg(int slot, logic pm, dataWordT val);
    accPm = pm;
    dmdIn = pm ? ~val : val;
    pmdIn = pm ? val : ~val;
    loadAx0 = (slot == 0);
    loadAx1 = (slot == 1);
    loadAy0 = (slot == 2);
    loadAy1 = (slot == 3);
    mOp[bank][slot] = val;
    step();
  endtask

  task automatic moveToAr(logic pm, dataWordT val);
    accPm = pm;
    dmdIn = pm ? ~val : val;
    pmdIn = pm ? val : ~val;
    moveAr = 1'b1;
    mAr[bank] = val;
    step();
  endtask

  task automatic issueOp(aluOpT op, xSrcT xs, ySrcT ys, logic zx, logic zy, logic ix,
                         logic iy, dataWordT cv, logic sat, logic af);
    dataWordT xv, yv, res;
    logic [19:0] r;
    astatT fl;
    case (xs)
      xAx0:    xv = mOp[bank][0];
      xAx1:    xv = mOp[bank][1];
      default: xv = mAr[bank];
    endcase
    case (ys)
      yAy0:    yv = mOp[bank][2];
      yAy1:    yv = mOp[bank][3];
      yAf:     yv = mAf[bank];
      default: yv = cv;
    endcase
    r = refAlu(op, xv, yv, zx, zy, ix, iy);
    res = r[15:0];
    fl = r[19:16];
    execute = 1'b1;
    aluOp = op;
    xSrc = xs;
    ySrc = ys;
    {zeroX, zeroY, invX, invY, satEn, toAf} = {zx, zy, ix, iy, sat, af};
    constVal = cv;
    // AF keeps the raw result while AR may clamp
    if (af) mAf[bank] = res;
    else mAr[bank] = refSat(res, fl, sat);
    expectAt(cyc + 3, af ? mAf[bank] : mAr[bank], fl);
    readAt[cyc + 3] = af ? rdAf : rdAr;
    mAstat = fl;
    step();
  endtask

  task automatic randomOp(logic pipeSafe);
    xSrcT xs;
    ySrcT ys;
    xs = xSrcT'(2'($urandom_range(pipeSafe ? 1 : 2, 0)));
    ys = ySrcT'(2'($urandom_range(3, 0)));
    if (pipeSafe && ys == yAf) ys = yConst;
    issueOp(aluOpT'(3'($urandom_range(7, 0))), xs, ys, coin(20), coin(20), coin(25),
            coin(25), 16'($urandom()), coin(50), coin(30));
  endtask

  initial begin
    void'($urandom(32'hd345650e));
    rst = 1'b1;
    dmdIn = '0;
    pmdIn = '0;
    constVal = '0;
    accPm = 1'b0;
    shadow = 1'b0;
    {loadAx0, loadAx1, loadAy0, loadAy1, moveAr, execute} = '0;
    aluOp = opAdd;
    xSrc = xAx0;
    ySrc = yAy0;
    readSrc = rdAx0;
    {zeroX, zeroY, invX, invY, satEn, toAf, readEn} = '0;
    mOp = '{default: '0};
    mAr = '{default: '0};
    mAf = '{default: '0};
    mAstat = '0;
    bank = 0;
    repeat (16) @(posedge DSPCLK);
    #1;
    rst = 1'b0;
    checkBank(0);
    checkBank(1);

    // Loads into both banks from both buses
    setBank(0);
    for (int slot = 0; slot < 4; slot++) loadReg(slot, slot[0], 16'($urandom()));
    checkBank(1);
    checkBank(0);
    setBank(1);
    for (int slot = 0; slot < 4; slot++) loadReg(slot, !slot[0], 16'($urandom()));
    checkBank(0);
    checkBank(1);

    // Overflow against the carry rule with and without saturation
    setBank(0);
    loadReg(0, 1'b0, 16'h7000);
    issueOp(opAdd, xAx0, yConst, 1'b0, 1'b0, 1'b0, 1'b0, 16'h7000, 1'b1, 1'b0);
    drain();
    readCheck(rdAr, 16'h7fff);
    issueOp(opAdd, xAx0, yConst, 1'b0, 1'b0, 1'b0, 1'b0, 16'h7000, 1'b0, 1'b0);
    drain();
    readCheck(rdAr, 16'he000);
    issueOp(opAdd, xAx0, yConst, 1'b0, 1'b0, 1'b0, 1'b0, 16'h7000, 1'b1, 1'b1);
    drain();
    readCheck(rdAf, 16'he000);
    loadReg(0, 1'b1, 16'h8000);
    issueOp(opSub, xAx0, yConst, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0001, 1'b1, 1'b0);
    drain();
    readCheck(rdAr, 16'h8000);

    repeat (300) begin
      if (coin(10)) setBank(int'($urandom_range(1, 0)));
      if (coin(40)) loadReg(int'($urandom_range(3, 0)), coin(50), 16'($urandom()));
      if (coin(10)) moveToAr(coin(50), 16'($urandom()));
      randomOp(1'b0);
      drain();
    end

    // Back-to-back issue keeps the pipeline full
    repeat (20) begin
      for (int slot = 0; slot < 4; slot++) loadReg(slot, coin(50), 16'($urandom()));
      repeat (4) randomOp(1'b1);
      drain();
    end

    // moveAr on the same edge as the stage 3 AR write
    repeat (4) begin
      issueOp(opAdd, xAx0, yAy0, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0, 1'b0, 1'b0);
      step();
      moveToAr(coin(50), 16'($urandom()));
      expVal[expVal.size() - 1] = mAr[bank];
      drain();
      issueOp(opPassX, xAr, yAy0, 1'b0, 1'b0, 1'b0, 1'b0, 16'h0, 1'b0, 1'b0);
      drain();
    end
    checkBank(0);
    checkBank(1);
    drain();
    $display("Test completed successfully");
    $finish;
  end

endmodule
